// ==== include/spu32_wb8_defines.svh ====
`ifndef SPU32_WB8_DEFINES_SVH
`define SPU32_WB8_DEFINES_SVH

// width of CPU and bus addresses
`define WB8_ADDR_W 32

// RAM address bits, RAM size is 2**WB8_RAM_AW bytes
`define WB8_RAM_AW 10

// memory map
// addresses at or above this base go to the I/O block
`define WB8_IO_BASE 32'h0001_0000

// value returned by the read-only ID byte at I/O offset 4
`define WB8_IO_ID 8'hA5

// RAM raises STALL in one cycle out of this many
`define WB8_STALL_PERIOD 4

`endif

// ==== src/spu32_wb8_pkg.sv ====
`default_nettype none

package spu32_wb8_pkg;

    // width of one CPU load/store access
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } access_size_e;

    // slave picked by the address decoder
    typedef enum logic {
        SLV_RAM,
        SLV_IO
    } wb8_slave_e;

endpackage

`default_nettype wire

// ==== src/wb8_if.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "spu32_wb8_defines.svh"

// 8-bit pipelined wishbone, one master and one slave per instance
interface wb8_if;

    logic [`WB8_ADDR_W-1:0] ADR;
    logic [7:0]             DAT_W;
    logic [7:0]             DAT_R;
    logic                   CYC;
    logic                   STB;
    logic                   WE;
    logic                   ACK;
    logic                   STALL;
    // driven from the top level
    logic                   RST;

    modport master (
        input  RST,
        input  DAT_R,
        input  ACK,
        input  STALL,
        output ADR,
        output DAT_W,
        output CYC,
        output STB,
        output WE
    );

    modport slave (
        input  RST,
        input  ADR,
        input  DAT_W,
        input  CYC,
        input  STB,
        input  WE,
        output DAT_R,
        output ACK,
        output STALL
    );

endinterface

`default_nettype wire

// ==== src/bus_wishbone8.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "spu32_wb8_defines.svh"

module bus_wishbone8 (
    input  logic                   I_clk,
    // CPU side
    input  logic                   strobe,
    input  logic                   write,
    input  logic                   halfword,
    input  logic                   fullword,
    input  logic [`WB8_ADDR_W-1:0] addr,
    input  logic [31:0]            data_in,
    output logic [31:0]            data_out,
    output logic                   wait_req,
    // bus side
    wb8_if.master                  wb
);

    spu32_wb8_pkg::access_size_e size;
    logic [2:0]  byte_target;
    logic [2:0]  issue_cnt;
    logic [2:0]  ack_cnt;
    logic [2:0]  ack_cnt_next;
    logic        done;
    logic        active;
    logic        can_issue;
    logic        stb_q;
    logic [7:0]  wr_lane;
    logic [31:0] buffer;

    function automatic logic [2:0] size_bytes(input spu32_wb8_pkg::access_size_e sz);
        case (sz)
            spu32_wb8_pkg::SIZE_WORD: size_bytes = 3'd4;
            spu32_wb8_pkg::SIZE_HALF: size_bytes = 3'd2;
            default:                  size_bytes = 3'd1;
        endcase
    endfunction

    always_comb begin
        case ({halfword, fullword})
            2'b01:   size = spu32_wb8_pkg::SIZE_WORD;
            2'b10:   size = spu32_wb8_pkg::SIZE_HALF;
            default: size = spu32_wb8_pkg::SIZE_BYTE;
        endcase
    end

    assign byte_target  = size_bytes(size);
    assign ack_cnt_next = ack_cnt + 3'd1;

    // done holds off a restart until the CPU drops strobe
    assign active = strobe && !done;

    // a new address may go out unless the current one is being stalled
    assign can_issue = !(stb_q && wb.STALL);

    always_comb begin
        case (issue_cnt[1:0])
            2'd0:    wr_lane = data_in[7:0];
            2'd1:    wr_lane = data_in[15:8];
            2'd2:    wr_lane = data_in[23:16];
            default: wr_lane = data_in[31:24];
        endcase
    end

    always_ff @(posedge I_clk) begin
        if (wb.RST) begin
            issue_cnt <= '0;
            ack_cnt   <= '0;
            stb_q     <= 1'b0;
            wb.CYC    <= 1'b0;
            wb.WE     <= 1'b0;
            wait_req  <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (!strobe) begin
                done <= 1'b0;
            end
            wait_req <= active;
            wb.CYC   <= active;
            wb.WE    <= active && write;

            if (active) begin
                if (can_issue) begin
                    if (issue_cnt != byte_target) begin
                        // base address plus number of bytes already issued
                        stb_q     <= 1'b1;
                        wb.ADR    <= addr + {{(`WB8_ADDR_W-3){1'b0}}, issue_cnt};
                        wb.DAT_W  <= wr_lane;
                        issue_cnt <= issue_cnt + 3'd1;
                    end else begin
                        stb_q <= 1'b0;
                    end
                end

                if (wb.ACK) begin
                    ack_cnt <= ack_cnt_next;
                    if (ack_cnt_next == byte_target) begin
                        // last byte back, release the CPU
                        wait_req  <= 1'b0;
                        wb.CYC    <= 1'b0;
                        wb.WE     <= 1'b0;
                        stb_q     <= 1'b0;
                        done      <= 1'b1;
                        issue_cnt <= '0;
                        ack_cnt   <= '0;
                    end
                end
            end else begin
                stb_q <= 1'b0;
            end
        end
    end

    // read bytes land little-endian in the lane picked by the ACK count
    always_ff @(posedge I_clk) begin
        if (active && wb.ACK && !wb.WE) begin
            case (ack_cnt[1:0])
                2'd0:    buffer[7:0]   <= wb.DAT_R;
                2'd1:    buffer[15:8]  <= wb.DAT_R;
                2'd2:    buffer[23:16] <= wb.DAT_R;
                default: buffer[31:24] <= wb.DAT_R;
            endcase
        end
    end

    assign wb.STB   = stb_q;
    assign data_out = buffer;

    a_stb_in_cycle: assert property (
        @(posedge I_clk) disable iff (wb.RST) wb.STB |-> wb.CYC);

    a_ack_bound: assert property (
        @(posedge I_clk) disable iff (wb.RST) ack_cnt <= byte_target);

    // a stalled transfer stays on the bus unchanged
    a_adr_hold: assert property (
        @(posedge I_clk) disable iff (wb.RST)
        (wb.STB && wb.STALL) |=> (wb.STB && $stable(wb.ADR)));

endmodule

`default_nettype wire

// ==== src/wb8_decoder.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "spu32_wb8_defines.svh"

module wb8_decoder (
    input  logic  I_clk,
    wb8_if.slave  m,
    wb8_if.master ram,
    wb8_if.master io
);

    spu32_wb8_pkg::wb8_slave_e sel;

    assign sel = (m.ADR >= `WB8_IO_BASE) ? spu32_wb8_pkg::SLV_IO
                                         : spu32_wb8_pkg::SLV_RAM;

    // request side goes to both slaves, STB only to the selected one
    assign ram.ADR   = m.ADR;
    assign ram.DAT_W = m.DAT_W;
    assign ram.CYC   = m.CYC;
    assign ram.WE    = m.WE;
    assign ram.STB   = m.STB && (sel == spu32_wb8_pkg::SLV_RAM);

    assign io.ADR    = m.ADR;
    assign io.DAT_W  = m.DAT_W;
    assign io.CYC    = m.CYC;
    assign io.WE     = m.WE;
    assign io.STB    = m.STB && (sel == spu32_wb8_pkg::SLV_IO);

    // stall follows the address currently presented
    assign m.STALL = (sel == spu32_wb8_pkg::SLV_IO) ? io.STALL : ram.STALL;

    // both slaves answer one cycle after acceptance, so ACKs stay ordered
    assign m.ACK   = ram.ACK | io.ACK;
    assign m.DAT_R = io.ACK ? io.DAT_R : ram.DAT_R;

    a_one_ack: assert property (
        @(posedge I_clk) disable iff (m.RST) !(ram.ACK && io.ACK));

    // an accepted transfer is answered by the slave it was routed to
    a_ram_resp: assert property (
        @(posedge I_clk) disable iff (m.RST)
        (m.CYC && m.STB && !m.STALL && sel == spu32_wb8_pkg::SLV_RAM) |=> ram.ACK);

    a_io_resp: assert property (
        @(posedge I_clk) disable iff (m.RST)
        (m.CYC && m.STB && !m.STALL && sel == spu32_wb8_pkg::SLV_IO) |=> io.ACK);

endmodule

`default_nettype wire

// ==== src/wb8_ram.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "spu32_wb8_defines.svh"

module wb8_ram (
    input logic  I_clk,
    wb8_if.slave wb
);

    localparam int DEPTH = 2 ** `WB8_RAM_AW;
    localparam int CNT_W = (`WB8_STALL_PERIOD > 1) ? $clog2(`WB8_STALL_PERIOD) : 1;

    logic [7:0]             mem [0:DEPTH-1];
    logic [`WB8_RAM_AW-1:0] idx;
    logic [CNT_W-1:0]       stall_cnt;
    logic                   accept;

    assign idx = wb.ADR[`WB8_RAM_AW-1:0];

    // free-running modulo counter, stall in its last count
    always_ff @(posedge I_clk) begin
        if (wb.RST) begin
            stall_cnt <= '0;
        end else if (stall_cnt == CNT_W'(`WB8_STALL_PERIOD - 1)) begin
            stall_cnt <= '0;
        end else begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    assign wb.STALL = (stall_cnt == CNT_W'(`WB8_STALL_PERIOD - 1));

    assign accept = wb.CYC && wb.STB && !wb.STALL;

    always_ff @(posedge I_clk) begin
        if (wb.RST) begin
            wb.ACK <= 1'b0;
        end else begin
            wb.ACK <= accept;
        end
    end

    // storage and read path
    always_ff @(posedge I_clk) begin
        if (accept) begin
            if (wb.WE) begin
                mem[idx] <= wb.DAT_W;
            end
            wb.DAT_R <= mem[idx];
        end
    end

    a_ack_after_accept: assert property (
        @(posedge I_clk) disable iff (wb.RST) wb.ACK |-> $past(accept));

endmodule

`default_nettype wire

// ==== src/wb8_io_regs.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "spu32_wb8_defines.svh"

module wb8_io_regs (
    input logic  I_clk,
    wb8_if.slave wb
);

    logic [7:0]             scratch [0:3];
    logic [`WB8_ADDR_W-1:0] offset;
    logic                   accept;
    logic [7:0]             rd_data;

    assign offset = wb.ADR - `WB8_IO_BASE;

    // never stalls
    assign wb.STALL = 1'b0;
    assign accept   = wb.CYC && wb.STB;

    always_comb begin
        case (offset)
            0, 1, 2, 3: rd_data = scratch[offset[1:0]];
            4:          rd_data = `WB8_IO_ID;
            default:    rd_data = 8'h00;
        endcase
    end

    always_ff @(posedge I_clk) begin
        if (wb.RST) begin
            wb.ACK <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                scratch[i] <= 8'h00;
            end
        end else begin
            wb.ACK <= accept;
            // only the scratch bytes are writable
            if (accept && wb.WE && offset < 4) begin
                scratch[offset[1:0]] <= wb.DAT_W;
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (accept) begin
            wb.DAT_R <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/spu32_wb8_top.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "spu32_wb8_defines.svh"

module spu32_wb8_top (
    input  logic                   I_clk,
    input  logic                   RST_I,
    input  logic                   I_strobe,
    input  logic                   I_write,
    input  logic                   I_halfword,
    input  logic                   I_fullword,
    input  logic [`WB8_ADDR_W-1:0] I_addr,
    input  logic [31:0]            I_data,
    output logic [31:0]            O_data,
    output logic                   O_wait
);

    wb8_if m_bus ();
    wb8_if ram_bus ();
    wb8_if io_bus ();

    // one reset for every bus segment
    assign m_bus.RST   = RST_I;
    assign ram_bus.RST = RST_I;
    assign io_bus.RST  = RST_I;

    bus_wishbone8 u_bridge (
        .I_clk    (I_clk),
        .strobe   (I_strobe),
        .write    (I_write),
        .halfword (I_halfword),
        .fullword (I_fullword),
        .addr     (I_addr),
        .data_in  (I_data),
        .data_out (O_data),
        .wait_req (O_wait),
        .wb       (m_bus)
    );

    wb8_decoder u_decoder (
        .I_clk (I_clk),
        .m     (m_bus),
        .ram   (ram_bus),
        .io    (io_bus)
    );

    wb8_ram u_ram (
        .I_clk (I_clk),
        .wb    (ram_bus)
    );

    wb8_io_regs u_io (
        .I_clk (I_clk),
        .wb    (io_bus)
    );

endmodule

`default_nettype wire

// ==== verif/tb_spu32_wb8.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "spu32_wb8_defines.svh"

module tb_spu32_wb8;

    localparam int CLK_HALF   = 50;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    // 2 + 4 + 24 + 6 + 2 + 60 accesses over the six tests
    localparam int N_ACCESSES = 98;
    localparam int WATCHDOG_CYCLES = N_ACCESSES * 20 + 40;

    logic                   I_clk;
    logic                   RST_I;
    logic                   I_strobe;
    logic                   I_write;
    logic                   I_halfword;
    logic                   I_fullword;
    logic [`WB8_ADDR_W-1:0] I_addr;
    logic [31:0]            I_data;
    logic [31:0]            O_data;
    logic                   O_wait;

    // reference model of the RAM bytes written so far and the I/O scratch bytes
    logic [7:0]             ram_model [logic [`WB8_RAM_AW-1:0]];
    logic [7:0]             io_model [0:3];

    logic                   check_req;
    logic [31:0]            exp_data;
    logic [31:0]            exp_mask;
    logic [`WB8_ADDR_W-1:0] check_addr;
    logic [31:0]            lfsr_state;
    int                     error_count;
    int                     errors_before;
    int                     read_count;
    int                     test_count;

    spu32_wb8_top u_spu32_wb8_top (
        .I_clk      (I_clk),
        .RST_I      (RST_I),
        .I_strobe   (I_strobe),
        .I_write    (I_write),
        .I_halfword (I_halfword),
        .I_fullword (I_fullword),
        .I_addr     (I_addr),
        .I_data     (I_data),
        .O_data     (O_data),
        .O_wait     (O_wait)
    );

    always #(CLK_HALF) I_clk = ~I_clk;

    // only the lanes the model knows are compared
    a_read_match: assert property (
        @(posedge I_clk) check_req |-> ((O_data & exp_mask) == (exp_data & exp_mask)))
    else begin
        error_count++;
        $display("ERROR %0t: read at 0x%08h gave 0x%08h, expected 0x%08h (mask 0x%08h)",
                 $time, check_addr, O_data, exp_data, exp_mask);
    end

    a_idle_after_reset: assert property (@(posedge I_clk) $fell(RST_I) |-> !O_wait)
    else begin
        error_count++;
        $display("ERROR %0t: O_wait is high right after reset", $time);
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic spu32_wb8_pkg::access_size_e size_from_index(input int k);
        case (k)
            0:       return spu32_wb8_pkg::SIZE_BYTE;
            1:       return spu32_wb8_pkg::SIZE_HALF;
            default: return spu32_wb8_pkg::SIZE_WORD;
        endcase
    endfunction

    function automatic int byte_count(input spu32_wb8_pkg::access_size_e sz);
        case (sz)
            spu32_wb8_pkg::SIZE_WORD: return 4;
            spu32_wb8_pkg::SIZE_HALF: return 2;
            default:                  return 1;
        endcase
    endfunction

    // byte i of the CPU word goes to address a + i
    function automatic void model_write(input logic [31:0] a, input int n, input logic [31:0] d);
        logic [31:0] ba;
        logic [31:0] off;
        for (int i = 0; i < n; i++) begin
            ba  = a + 32'(i);
            off = ba - `WB8_IO_BASE;
            if (ba < `WB8_IO_BASE) begin
                ram_model[ba[`WB8_RAM_AW-1:0]] = d[8*i +: 8];
            end else if (off < 32'd4) begin
                io_model[off[1:0]] = d[8*i +: 8];
            end
        end
    endfunction

    function automatic void model_expect(input logic [31:0] a, input int n,
                                         output logic [31:0] data, output logic [31:0] mask);
        logic [31:0] ba;
        logic [31:0] off;
        data = '0;
        mask = '0;
        for (int i = 0; i < n; i++) begin
            ba  = a + 32'(i);
            off = ba - `WB8_IO_BASE;
            if (ba >= `WB8_IO_BASE) begin
                mask[8*i +: 8] = 8'hFF;
                if (off < 32'd4) begin
                    data[8*i +: 8] = io_model[off[1:0]];
                end else if (off == 32'd4) begin
                    data[8*i +: 8] = `WB8_IO_ID;
                end
            end else if (ram_model.exists(ba[`WB8_RAM_AW-1:0])) begin
                mask[8*i +: 8] = 8'hFF;
                data[8*i +: 8] = ram_model[ba[`WB8_RAM_AW-1:0]];
            end
        end
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge I_clk);
            #1;
        end
    endtask

    // one load or store, starting 1 ns after a rising edge
    task automatic cpu_access(input logic wr, input spu32_wb8_pkg::access_size_e sz,
                              input logic [31:0] a, input logic [31:0] d);
        I_addr     = a;
        I_data     = d;
        I_write    = wr;
        I_halfword = (sz == spu32_wb8_pkg::SIZE_HALF);
        I_fullword = (sz == spu32_wb8_pkg::SIZE_WORD);
        I_strobe   = 1'b1;
        do idle(1); while (!O_wait);
        do idle(1); while (O_wait);
        if (wr) begin
            model_write(a, byte_count(sz), d);
        end else begin
            model_expect(a, byte_count(sz), exp_data, exp_mask);
            check_addr = a;
            check_req  = 1'b1;
            read_count++;
        end
        // strobe stays low for one cycle, the check fires on that edge
        I_strobe = 1'b0;
        idle(1);
        check_req = 1'b0;
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the accesses did not complete in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] addr_v;
        logic [31:0] data_v;
        logic        wr_v;
        int          sel;
        I_clk      = 1'b0;
        RST_I      = 1'b1;
        I_strobe   = 1'b0;
        I_write    = 1'b0;
        I_halfword = 1'b0;
        I_fullword = 1'b0;
        I_addr     = '0;
        I_data     = '0;
        check_req  = 1'b0;
        exp_data   = '0;
        exp_mask   = '0;
        check_addr = '0;
        lfsr_state = 32'ha504;
        error_count   = 0;
        errors_before = 0;
        read_count    = 0;
        test_count    = 0;
        for (int i = 0; i < 4; i++) begin
            io_model[i] = 8'h00;
        end
        repeat (3) @(posedge I_clk);
        #1;
        RST_I = 1'b0;
        idle(1);

        cpu_access(1'b1, spu32_wb8_pkg::SIZE_WORD, 32'h0000_0010, 32'hDEAD_BEEF);
        cpu_access(1'b0, spu32_wb8_pkg::SIZE_WORD, 32'h0000_0010, 32'h0);
        report_test("reset state and word write/read");

        cpu_access(1'b1, spu32_wb8_pkg::SIZE_WORD, 32'h0000_0040, 32'h1122_3344);
        cpu_access(1'b1, spu32_wb8_pkg::SIZE_BYTE, 32'h0000_0041, 32'h0000_00AB);
        cpu_access(1'b1, spu32_wb8_pkg::SIZE_HALF, 32'h0000_0042, 32'h0000_CDEF);
        cpu_access(1'b0, spu32_wb8_pkg::SIZE_WORD, 32'h0000_0040, 32'h0);
        report_test("byte and halfword merge");

        // idle gaps shift each access against the RAM stall phase
        for (int gap = 0; gap < 4; gap++) begin
            for (int s = 0; s < 3; s++) begin
                addr_v = 32'h0000_0100 + 32'(16 * gap + 4 * s + gap);
                data_v = rand_bits(32);
                cpu_access(1'b1, size_from_index(s), addr_v, data_v);
                idle(gap);
                cpu_access(1'b0, size_from_index(s), addr_v, 32'h0);
            end
        end
        report_test("accesses across stall cycles");

        cpu_access(1'b1, spu32_wb8_pkg::SIZE_WORD, `WB8_IO_BASE, 32'h4433_2211);
        cpu_access(1'b0, spu32_wb8_pkg::SIZE_WORD, `WB8_IO_BASE, 32'h0);
        cpu_access(1'b0, spu32_wb8_pkg::SIZE_BYTE, `WB8_IO_BASE + 32'd4, 32'h0);
        cpu_access(1'b1, spu32_wb8_pkg::SIZE_BYTE, `WB8_IO_BASE + 32'd4, 32'h0000_005A);
        cpu_access(1'b0, spu32_wb8_pkg::SIZE_BYTE, `WB8_IO_BASE + 32'd4, 32'h0);
        cpu_access(1'b0, spu32_wb8_pkg::SIZE_HALF, `WB8_IO_BASE + 32'd5, 32'h0);
        report_test("I/O scratch and ID bytes");

        cpu_access(1'b1, spu32_wb8_pkg::SIZE_WORD, `WB8_IO_BASE - 32'd2, 32'h8877_6655);
        cpu_access(1'b0, spu32_wb8_pkg::SIZE_WORD, `WB8_IO_BASE - 32'd2, 32'h0);
        report_test("word across the I/O base");

        // small window at the top of the RAM, so reads find written bytes
        // and words running past the end wrap to index 0
        for (int k = 0; k < 60; k++) begin
            sel    = int'(rand_bits(2) % 32'd3);
            addr_v = 32'h0000_03E0 + rand_bits(5);
            data_v = rand_bits(32);
            wr_v   = rand_bits(1) != 32'd0;
            cpu_access(wr_v, size_from_index(sel), addr_v, data_v);
        end
        report_test("random RAM accesses");

        $display("tests: %0d, reads checked: %0d, errors: %0d",
                 test_count, read_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== spu32_wb8.f ====
+incdir+include
src/spu32_wb8_pkg.sv
src/wb8_if.sv
src/bus_wishbone8.sv
src/wb8_decoder.sv
src/wb8_ram.sv
src/wb8_io_regs.sv
src/spu32_wb8_top.sv
verif/tb_spu32_wb8.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_spu32_wb8 \
    -f spu32_wb8.f &&
./obj_dir/Vtb_spu32_wb8 | tee /dev/stderr | grep -F "TESTBENCH PASSED" > /dev/null &&
echo "simulation run ok" ||
{ echo "simulation run not ok"; exit 1; }
